/* cipher_ctrl/aes_cipher_ctrl.sv */
/*
  AES cipher control top level
  Joins the sparse input checker, the protected round counter and the FSM
*/
`timescale 1ns/10ps
`include "aes_ctrl_macros.svh"

module aes_cipher_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  aes_ctrl_pkg::sp2v_e          in_valid_i,
  output aes_ctrl_pkg::sp2v_e          in_ready_o,
  output aes_ctrl_pkg::sp2v_e          out_valid_o,
  input  aes_ctrl_pkg::sp2v_e          out_ready_i,
  input  aes_ctrl_pkg::ciph_op_e       op_i,
  input  aes_ctrl_pkg::key_len_e       key_len_i,
  input  aes_ctrl_pkg::sp2v_e          crypt_i,
  output aes_ctrl_pkg::sp2v_e          crypt_o,
  input  logic                         key_clear_i,
  output logic                         key_clear_o,
  input  logic                         data_out_clear_i,
  output logic                         data_out_clear_o,
  output logic                         alert_o,
  output aes_ctrl_pkg::state_sel_e     state_sel_o,
  output aes_ctrl_pkg::sp2v_e          state_we_o,
  output aes_ctrl_pkg::add_rk_sel_e    add_rk_sel_o,
  output aes_ctrl_pkg::sp2v_e          sub_bytes_en_o,
  input  aes_ctrl_pkg::sp2v_e          sub_bytes_out_req_i,
  output aes_ctrl_pkg::sp2v_e          sub_bytes_out_ack_o,
  output aes_ctrl_pkg::key_full_sel_e  key_full_sel_o,
  output aes_ctrl_pkg::sp2v_e          key_full_we_o,
  output aes_ctrl_pkg::sp2v_e          key_expand_en_o,
  input  aes_ctrl_pkg::sp2v_e          key_expand_out_req_i,
  output aes_ctrl_pkg::sp2v_e          key_expand_out_ack_o,
  output logic                         key_expand_clear_o,
  output logic [`AES_RND_W-1:0]        key_expand_round_o,
  output aes_ctrl_pkg::key_words_sel_e key_words_sel_o
);

  // Decoded inputs and round counter links
  sp2v_chk_if u_chk_if (.clk_i, .rst_ni);
  rnd_ctr_if  u_ctr_if ();

  aes_sp2v_check u_sp2v_check (
    .in_valid_i,
    .out_ready_i,
    .crypt_i,
    .sub_bytes_out_req_i,
    .key_expand_out_req_i,
    .chk_o (u_chk_if.chk)
  );

  aes_round_ctr u_round_ctr (
    .clk_i,
    .rst_ni,
    .ctr_o (u_ctr_if.ctr)
  );

  aes_cipher_fsm u_cipher_fsm (
    .clk_i,
    .rst_ni,
    .chk_i (u_chk_if.fsm),
    .ctr_i (u_ctr_if.fsm),
    .op_i,
    .key_len_i,
    .key_clear_i,
    .data_out_clear_i,
    .in_ready_o,
    .out_valid_o,
    .crypt_o,
    .key_clear_o,
    .data_out_clear_o,
    .alert_o,
    .state_sel_o,
    .state_we_o,
    .add_rk_sel_o,
    .sub_bytes_en_o,
    .sub_bytes_out_ack_o,
    .key_full_sel_o,
    .key_full_we_o,
    .key_expand_en_o,
    .key_expand_out_ack_o,
    .key_expand_clear_o,
    .key_expand_round_o,
    .key_words_sel_o
  );

endmodule

/* cipher_ctrl/aes_cipher_fsm.sv */
/*
  AES cipher round sequencing FSM
  Steps through initial, regular and final rounds, clears keys/data, traps faults
*/
`timescale 1ns/10ps
`include "aes_ctrl_macros.svh"

module aes_cipher_fsm (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  sp2v_chk_if.fsm                      chk_i,
  rnd_ctr_if.fsm                       ctr_i,
  input  aes_ctrl_pkg::ciph_op_e       op_i,
  input  aes_ctrl_pkg::key_len_e       key_len_i,
  input  logic                         key_clear_i,
  input  logic                         data_out_clear_i,
  output aes_ctrl_pkg::sp2v_e          in_ready_o,
  output aes_ctrl_pkg::sp2v_e          out_valid_o,
  output aes_ctrl_pkg::sp2v_e          crypt_o,
  output logic                         key_clear_o,
  output logic                         data_out_clear_o,
  output logic                         alert_o,
  output aes_ctrl_pkg::state_sel_e     state_sel_o,
  output aes_ctrl_pkg::sp2v_e          state_we_o,
  output aes_ctrl_pkg::add_rk_sel_e    add_rk_sel_o,
  output aes_ctrl_pkg::sp2v_e          sub_bytes_en_o,
  output aes_ctrl_pkg::sp2v_e          sub_bytes_out_ack_o,
  output aes_ctrl_pkg::key_full_sel_e  key_full_sel_o,
  output aes_ctrl_pkg::sp2v_e          key_full_we_o,
  output aes_ctrl_pkg::sp2v_e          key_expand_en_o,
  output aes_ctrl_pkg::sp2v_e          key_expand_out_ack_o,
  output logic                         key_expand_clear_o,
  output logic [`AES_RND_W-1:0]        key_expand_round_o,
  output aes_ctrl_pkg::key_words_sel_e key_words_sel_o
);
  import aes_ctrl_pkg::*;

  localparam int unsigned RndW = `AES_RND_W;

  // Sparse state codes, minimum Hamming distance 3
  typedef enum logic [5:0] {
    IDLE     = 6'b100110,
    INIT     = 6'b010101,
    ROUND    = 6'b001011,
    FINISH   = 6'b110011,
    CLEAR_S  = 6'b101101,
    CLEAR_KD = 6'b011110,
    ERROR    = 6'b111000
  } fsm_state_e;

  fsm_state_e      state_d, state_q;
  sp2v_e           crypt_d, crypt_q;
  logic            key_clear_d, key_clear_q;
  logic            data_out_clear_d, data_out_clear_q;
  logic [RndW-1:0] last_rnd;

  // Wider key window, picked only in the direction given by hi_op
  function automatic key_words_sel_e words_sel(key_len_e len, ciph_op_e op, ciph_op_e hi_op);
    key_words_sel_e sel;
    sel = KEY_WORDS_0123;
    if (op == hi_op) begin
      if (len == AES_192) begin
        sel = KEY_WORDS_2345;
      end else if (len == AES_256) begin
        sel = KEY_WORDS_4567;
      end
    end
    return sel;
  endfunction

  // Round total, sampled by the counter on load
  assign ctr_i.num_rounds = (key_len_i == AES_128) ? RndW'(`AES_NR_128) :
                            (key_len_i == AES_192) ? RndW'(`AES_NR_192) :
                                                     RndW'(`AES_NR_256);
  // Index of the last regular round
  assign last_rnd = ctr_i.num_rounds - RndW'(1);

  //////////////////////////////
  // Next state and outputs
  //////////////////////////////

  always_comb begin : fsm_comb
    in_ready_o           = SP2V_LOW;
    out_valid_o          = SP2V_LOW;
    alert_o              = 1'b0;
    state_sel_o          = STATE_ROUND;
    state_we_o           = SP2V_LOW;
    add_rk_sel_o         = ADD_RK_ROUND;
    sub_bytes_en_o       = SP2V_LOW;
    sub_bytes_out_ack_o  = SP2V_LOW;
    key_full_sel_o       = KEY_FULL_ROUND;
    key_full_we_o        = SP2V_LOW;
    key_expand_en_o      = SP2V_LOW;
    key_expand_out_ack_o = SP2V_LOW;
    key_expand_clear_o   = 1'b0;
    key_words_sel_o      = KEY_WORDS_ZERO;
    ctr_i.load           = 1'b0;
    ctr_i.step           = 1'b0;
    state_d              = state_q;
    crypt_d              = crypt_q;
    key_clear_d          = key_clear_q;
    data_out_clear_d     = data_out_clear_q;

    unique case (state_q)
      IDLE: begin
        in_ready_o = SP2V_HIGH;
        if (chk_i.in_valid) begin
          if (key_clear_i || data_out_clear_i) begin
            key_clear_d      = key_clear_i;
            data_out_clear_d = data_out_clear_i;
            // Data output clear goes through a cleared state first
            state_d = data_out_clear_i ? CLEAR_S : CLEAR_KD;
          end else if (chk_i.crypt) begin
            crypt_d            = SP2V_HIGH;
            state_sel_o        = STATE_INIT;
            state_we_o         = SP2V_HIGH;
            key_expand_clear_o = 1'b1;
            key_full_sel_o     = (op_i == CIPH_FWD) ? KEY_FULL_ENC_INIT : KEY_FULL_DEC_INIT;
            key_full_we_o      = SP2V_HIGH;
            ctr_i.load         = 1'b1;
            state_d            = INIT;
          end else begin
            // Transfer without any command is treated as a fault
            state_d = ERROR;
          end
        end
      end

      INIT: begin
        add_rk_sel_o    = ADD_RK_INIT;
        key_words_sel_o = words_sel(key_len_i, op_i, CIPH_INV);
        if (key_len_i != AES_256) begin
          // Need the second round key from KeyExpand
          key_expand_en_o = SP2V_HIGH;
          if (chk_i.key_expand_req) begin
            key_expand_out_ack_o = SP2V_HIGH;
            state_we_o           = SP2V_HIGH;
            key_full_we_o        = SP2V_HIGH;
            ctr_i.step           = 1'b1;
            state_d              = ROUND;
          end
        end else begin
          // Both first round keys already in the full key
          state_we_o = SP2V_HIGH;
          ctr_i.step = 1'b1;
          state_d    = ROUND;
        end
      end

      ROUND: begin
        key_words_sel_o = words_sel(key_len_i, op_i, CIPH_FWD);
        sub_bytes_en_o  = SP2V_HIGH;
        key_expand_en_o = SP2V_HIGH;
        // Advance only when both units are done
        if (chk_i.sub_bytes_req && chk_i.key_expand_req) begin
          sub_bytes_out_ack_o  = SP2V_HIGH;
          key_expand_out_ack_o = SP2V_HIGH;
          state_we_o           = SP2V_HIGH;
          key_full_we_o        = SP2V_HIGH;
          ctr_i.step           = 1'b1;
          if (ctr_i.rnd == last_rnd) begin
            state_d = FINISH;
          end
        end
      end

      FINISH: begin
        key_words_sel_o = words_sel(key_len_i, op_i, CIPH_FWD);
        add_rk_sel_o    = ADD_RK_FINAL;
        // State gets wiped on the way out
        state_sel_o     = STATE_CLEAR;
        sub_bytes_en_o  = SP2V_HIGH;
        // No data release on a bad input code
        out_valid_o = (chk_i.sub_bytes_req && !chk_i.enc_err) ? SP2V_HIGH : SP2V_LOW;
        if (out_valid_o == SP2V_HIGH && chk_i.out_ready) begin
          sub_bytes_out_ack_o = SP2V_HIGH;
          state_we_o          = SP2V_HIGH;
          crypt_d             = SP2V_LOW;
          state_d             = IDLE;
        end
      end

      CLEAR_S: begin
        state_sel_o = STATE_CLEAR;
        state_we_o  = SP2V_HIGH;
        state_d     = CLEAR_KD;
      end

      CLEAR_KD: begin
        if (key_clear_q) begin
          key_full_sel_o = KEY_FULL_CLEAR;
          key_full_we_o  = SP2V_HIGH;
        end
        if (data_out_clear_q) begin
          // Pass the cleared state straight to the output
          add_rk_sel_o = ADD_RK_INIT;
        end
        out_valid_o = SP2V_HIGH;
        if (chk_i.out_ready) begin
          key_clear_d      = 1'b0;
          data_out_clear_d = 1'b0;
          state_d          = IDLE;
        end
      end

      ERROR: begin
        // Terminal, left only through reset
        alert_o = 1'b1;
      end

      default: begin
        state_d = ERROR;
      end
    endcase

    // Any fault overrides the regular transition
    if (chk_i.enc_err || ctr_i.rnd_err) begin
      state_d = ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= IDLE;
      crypt_q          <= SP2V_LOW;
      key_clear_q      <= 1'b0;
      data_out_clear_q <= 1'b0;
    end else begin
      state_q          <= state_d;
      crypt_q          <= crypt_d;
      key_clear_q      <= key_clear_d;
      data_out_clear_q <= data_out_clear_d;
    end
  end

  assign crypt_o            = crypt_q;
  assign key_clear_o        = key_clear_q;
  assign data_out_clear_o   = data_out_clear_q;
  assign key_expand_round_o = ctr_i.rnd;

  // Key length must stay legal for the whole operation
  key_len_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q != IDLE) |-> $onehot(key_len_i));

endmodule

/* common/aes_ctrl_if.sv */
/*
  Internal links of the AES round controller
  Decoded sparse inputs to the FSM, and the FSM to round counter path
*/
`timescale 1ns/10ps
`include "aes_ctrl_macros.svh"

// Decoded handshake inputs, purely combinational
interface sp2v_chk_if (
  input logic clk_i,
  input logic rst_ni
);
  logic in_valid;
  logic out_ready;
  logic crypt;
  logic sub_bytes_req;
  logic key_expand_req;
  // Any input code outside HIGH/LOW
  logic enc_err;

  // Clock and reset only serve the checker assertion
  modport chk (
    input  clk_i, rst_ni,
    output in_valid, out_ready, crypt, sub_bytes_req, key_expand_req, enc_err
  );

  modport fsm (
    input in_valid, out_ready, crypt, sub_bytes_req, key_expand_req, enc_err
  );
endinterface

// Protected round counter control and status
interface rnd_ctr_if;
  logic                  load;
  logic                  step;
  logic [`AES_RND_W-1:0] num_rounds;
  logic [`AES_RND_W-1:0] rnd;
  logic                  rnd_err;

  modport ctr (input load, step, num_rounds, output rnd, rnd_err);

  modport fsm (output load, step, num_rounds, input rnd, rnd_err);
endinterface

/* common/aes_ctrl_macros.svh */
/*
  AES round controller constants
  Round counts per key length and the widths of shared fields
*/
`ifndef AES_CTRL_MACROS_SVH
`define AES_CTRL_MACROS_SVH

// Rounds per key length
`define AES_NR_128 10
`define AES_NR_192 12
`define AES_NR_256 14

// Round counter width, also the width of the KeyExpand round index
`define AES_RND_W 4

// Width of a sparse two-value signal
`define AES_SP2V_W 3

`endif

/* common/aes_ctrl_pkg.sv */
/*
  AES round controller package
  Sparse encodings and datapath select codes
*/
`include "aes_ctrl_macros.svh"

package aes_ctrl_pkg;

  // Sparse boolean, all other codes are invalid
  typedef enum logic [`AES_SP2V_W-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // One-hot key length
  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  // State register input select
  typedef enum logic [1:0] {
    STATE_INIT  = 2'b00,
    STATE_ROUND = 2'b01,
    STATE_CLEAR = 2'b10
  } state_sel_e;

  // AddRoundKey operand select
  typedef enum logic [1:0] {
    ADD_RK_INIT  = 2'b00,
    ADD_RK_ROUND = 2'b01,
    ADD_RK_FINAL = 2'b10
  } add_rk_sel_e;

  // Full key register input select
  typedef enum logic [1:0] {
    KEY_FULL_ENC_INIT = 2'b00,
    KEY_FULL_DEC_INIT = 2'b01,
    KEY_FULL_ROUND    = 2'b10,
    KEY_FULL_CLEAR    = 2'b11
  } key_full_sel_e;

  // Round key word window
  typedef enum logic [1:0] {
    KEY_WORDS_0123 = 2'b00,
    KEY_WORDS_2345 = 2'b01,
    KEY_WORDS_4567 = 2'b10,
    KEY_WORDS_ZERO = 2'b11
  } key_words_sel_e;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the AES cipher control testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_aes_cipher_ctrl -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_aes_cipher_ctrl > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0

/* src/aes_round_ctr.sv */
/*
  Protected AES round counter
  Up-counter, down-counter and parity bit, cross-checked every cycle
*/
`timescale 1ns/10ps
`include "aes_ctrl_macros.svh"

module aes_round_ctr (
  input logic    clk_i,
  input logic    rst_ni,
  rnd_ctr_if.ctr ctr_o
);
  localparam int unsigned RndW = `AES_RND_W;

  logic [RndW-1:0] up_q;
  logic [RndW-1:0] down_q;
  logic [RndW-1:0] total_q;
  logic [RndW-1:0] up_inc;
  logic [RndW-1:0] sum;
  logic            par_q;
  logic            err_sum;
  logic            err_par;

  assign up_inc = up_q + RndW'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      up_q    <= '0;
      down_q  <= '0;
      total_q <= '0;
      par_q   <= 1'b0;
    end else if (ctr_o.load) begin
      // Fresh operation, parity of zero is zero
      up_q    <= '0;
      down_q  <= ctr_o.num_rounds;
      total_q <= ctr_o.num_rounds;
      par_q   <= 1'b0;
    end else if (ctr_o.step) begin
      up_q    <= up_inc;
      down_q  <= down_q - RndW'(1);
      par_q   <= ^up_inc;
    end
  end

  //////////////////////////////
  // Consistency checks
  //////////////////////////////

  // Both counters must always add up to the stored total
  assign sum     = up_q + down_q;
  assign err_sum = (sum != total_q);
  // Stored parity must match recomputed parity
  assign err_par = (par_q != ^up_q);

  assign ctr_o.rnd     = up_q;
  assign ctr_o.rnd_err = err_sum | err_par;

  // FSM must stop stepping once all rounds are done
  no_step_past_end_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctr_o.step |-> (up_q != total_q));

endmodule

/* src/aes_sp2v_check.sv */
/*
  Sparse input checker
  Decodes sparse handshake inputs and flags any invalid code
*/
`timescale 1ns/10ps

module aes_sp2v_check (
  input  aes_ctrl_pkg::sp2v_e in_valid_i,
  input  aes_ctrl_pkg::sp2v_e out_ready_i,
  input  aes_ctrl_pkg::sp2v_e crypt_i,
  input  aes_ctrl_pkg::sp2v_e sub_bytes_out_req_i,
  input  aes_ctrl_pkg::sp2v_e key_expand_out_req_i,
  sp2v_chk_if.chk             chk_o
);
  import aes_ctrl_pkg::*;

  logic [4:0] bad;

  // Only the exact HIGH code counts as true
  assign chk_o.in_valid       = (in_valid_i == SP2V_HIGH);
  assign chk_o.out_ready      = (out_ready_i == SP2V_HIGH);
  assign chk_o.crypt          = (crypt_i == SP2V_HIGH);
  assign chk_o.sub_bytes_req  = (sub_bytes_out_req_i == SP2V_HIGH);
  assign chk_o.key_expand_req = (key_expand_out_req_i == SP2V_HIGH);

  // Per-input invalid code flags
  assign bad[0] = !(in_valid_i inside {SP2V_HIGH, SP2V_LOW});
  assign bad[1] = !(out_ready_i inside {SP2V_HIGH, SP2V_LOW});
  assign bad[2] = !(crypt_i inside {SP2V_HIGH, SP2V_LOW});
  assign bad[3] = !(sub_bytes_out_req_i inside {SP2V_HIGH, SP2V_LOW});
  assign bad[4] = !(key_expand_out_req_i inside {SP2V_HIGH, SP2V_LOW});

  assign chk_o.enc_err = |bad;

  // Driving logic upstream must never float these once out of reset
  inputs_known_a: assert property (@(posedge chk_o.clk_i) disable iff (!chk_o.rst_ni)
    !$isunknown({in_valid_i, out_ready_i, crypt_i, sub_bytes_out_req_i, key_expand_out_req_i}));

endmodule

/* test/tb_aes_cipher_ctrl.sv */
/*
  Testbench for the AES cipher control top level
  Models SubBytes and KeyExpand units, checks round counts, key selects and clears
*/
`timescale 1ns/10ps
`include "aes_ctrl_macros.svh"

module tb_aes_cipher_ctrl;
  import aes_ctrl_pkg::*;

  // Room for 20 commands of up to 60 cycles each
  localparam int MaxCycles = 20 * 60;

  typedef struct packed {
    int             sb_acks;
    int             ke_acks;
    int             ke_round_base;
    key_words_sel_e init_words;
    key_words_sel_e round_words;
    key_full_sel_e  start_sel;
  } exp_t;

  logic                  clk_i;
  logic                  rst_ni;
  sp2v_e                 in_valid_i;
  sp2v_e                 out_ready_i;
  sp2v_e                 crypt_i;
  sp2v_e                 sub_bytes_out_req_i;
  sp2v_e                 key_expand_out_req_i;
  ciph_op_e              op_i;
  key_len_e              key_len_i;
  logic                  key_clear_i;
  logic                  data_out_clear_i;
  sp2v_e                 in_ready_o;
  sp2v_e                 out_valid_o;
  sp2v_e                 crypt_o;
  sp2v_e                 state_we_o;
  sp2v_e                 sub_bytes_en_o;
  sp2v_e                 sub_bytes_out_ack_o;
  sp2v_e                 key_full_we_o;
  sp2v_e                 key_expand_en_o;
  sp2v_e                 key_expand_out_ack_o;
  logic                  key_clear_o;
  logic                  data_out_clear_o;
  logic                  alert_o;
  logic                  key_expand_clear_o;
  state_sel_e            state_sel_o;
  add_rk_sel_e           add_rk_sel_o;
  key_full_sel_e         key_full_sel_o;
  key_words_sel_e        key_words_sel_o;
  logic [`AES_RND_W-1:0] key_expand_round_o;

  // Values seen at the last rising edge, used by the unit models
  logic sb_acked;
  logic ke_acked;
  logic sb_en_seen;
  logic ke_en_seen;
  // Operation already running at the previous rising edge
  logic crypt_seen = 1'b0;
  int   sb_count;
  int   ke_count;
  int   sb_wait;
  int   ke_wait;
  int   cycles = 0;
  int   seed = 2;

  aes_cipher_ctrl dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Reference and compare
  //////////////////////////////

  // Expected ack counts and selects for one operation
  function automatic exp_t expected_for(key_len_e len, ciph_op_e op);
    exp_t e;
    e.sb_acks = (len == AES_128) ? `AES_NR_128 : (len == AES_192) ? `AES_NR_192 : `AES_NR_256;
    // AES-256 has both first round keys at start, one KeyExpand step less
    e.ke_acks       = (len == AES_256) ? e.sb_acks - 1 : e.sb_acks;
    e.ke_round_base = (len == AES_256) ? 1 : 0;
    e.init_words    = KEY_WORDS_0123;
    e.round_words   = KEY_WORDS_0123;
    if (op == CIPH_INV && len == AES_192) e.init_words = KEY_WORDS_2345;
    if (op == CIPH_INV && len == AES_256) e.init_words = KEY_WORDS_4567;
    if (op == CIPH_FWD && len == AES_192) e.round_words = KEY_WORDS_2345;
    if (op == CIPH_FWD && len == AES_256) e.round_words = KEY_WORDS_4567;
    e.start_sel = (op == CIPH_FWD) ? KEY_FULL_ENC_INIT : KEY_FULL_DEC_INIT;
    return e;
  endfunction

  task automatic compare(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("error %s expected %0d actual %0d", name, expected, actual);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Per-cycle checks while an operation is running
  always @(posedge clk_i) begin : round_monitor
    exp_t        expv;
    add_rk_sel_e exp_rk;
    logic        in_init;
    sb_acked   = (sub_bytes_out_ack_o == SP2V_HIGH);
    ke_acked   = (key_expand_out_ack_o == SP2V_HIGH);
    sb_en_seen = (sub_bytes_en_o == SP2V_HIGH);
    ke_en_seen = (key_expand_en_o == SP2V_HIGH);
    if (rst_ni && crypt_o == SP2V_HIGH) begin
      expv = expected_for(key_len_i, op_i);
      // AES-256 spends one cycle in the initial round, others wait for KeyExpand
      in_init = (key_len_i == AES_256) ? !crypt_seen : (ke_count == 0);
      if (in_init) begin
        exp_rk = ADD_RK_INIT;
      end else if (sb_count == expv.sb_acks - 1) begin
        exp_rk = ADD_RK_FINAL;
      end else begin
        exp_rk = ADD_RK_ROUND;
      end
      compare("add round key sel", int'(exp_rk), int'(add_rk_sel_o));
      if (in_init) begin
        compare("init key words", int'(expv.init_words), int'(key_words_sel_o));
      end else begin
        compare("round key words", int'(expv.round_words), int'(key_words_sel_o));
      end
      if (key_full_we_o == SP2V_HIGH) begin
        compare("round key load", int'(KEY_FULL_ROUND), int'(key_full_sel_o));
      end
      if (sb_acked) sb_count = sb_count + 1;
      if (ke_acked) begin
        compare("key expand round", ke_count + expv.ke_round_base, int'(key_expand_round_o));
        ke_count = ke_count + 1;
      end
    end
    crypt_seen = rst_ni && (crypt_o == SP2V_HIGH);
  end

  always @(posedge clk_i) begin : cycle_limit
    cycles = cycles + 1;
    if (cycles > MaxCycles) begin
      $display("timeout, no progress after %0d cycles", cycles);
      $display("Testbench failed");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////
  // SubBytes and KeyExpand units
  //////////////////////////////

  // Req rises a random 0..2 cycles after enable, drops after the ack
  always @(negedge clk_i) begin : unit_models
    if (!rst_ni) begin
      sub_bytes_out_req_i  = SP2V_LOW;
      key_expand_out_req_i = SP2V_LOW;
      sb_wait              = -1;
      ke_wait              = -1;
    end else begin
      if (sb_acked) begin
        sub_bytes_out_req_i = SP2V_LOW;
        sb_wait             = -1;
      end else if (sub_bytes_out_req_i == SP2V_LOW && sb_en_seen) begin
        if (sb_wait < 0) sb_wait = $unsigned($random(seed)) % 3;
        if (sb_wait == 0) sub_bytes_out_req_i = SP2V_HIGH;
        else sb_wait = sb_wait - 1;
      end else if (!sb_en_seen) begin
        sb_wait = -1;
      end
      if (ke_acked) begin
        key_expand_out_req_i = SP2V_LOW;
        ke_wait              = -1;
      end else if (key_expand_out_req_i == SP2V_LOW && ke_en_seen) begin
        if (ke_wait < 0) ke_wait = $unsigned($random(seed)) % 3;
        if (ke_wait == 0) key_expand_out_req_i = SP2V_HIGH;
        else ke_wait = ke_wait - 1;
      end else if (!ke_en_seen) begin
        ke_wait = -1;
      end
    end
  end

  //////////////////////////////
  // Test sequences
  //////////////////////////////

  task automatic wait_out_valid();
    do @(posedge clk_i); while (out_valid_o != SP2V_HIGH);
  endtask

  task automatic crypt_round_trip(input key_len_e len, input ciph_op_e op);
    exp_t  expv;
    string name;
    expv = expected_for(len, op);
    name = $sformatf("crypt %s %s", len.name(), op.name());
    @(negedge clk_i);
    sb_count   = 0;
    ke_count   = 0;
    key_len_i  = len;
    op_i       = op;
    crypt_i    = SP2V_HIGH;
    in_valid_i = SP2V_HIGH;
    @(posedge clk_i);
    compare({name, " accept"}, int'(SP2V_HIGH), int'(in_ready_o));
    compare({name, " start key sel"}, int'(expv.start_sel), int'(key_full_sel_o));
    compare({name, " start key we"}, int'(SP2V_HIGH), int'(key_full_we_o));
    compare({name, " start state sel"}, int'(STATE_INIT), int'(state_sel_o));
    compare({name, " start state we"}, int'(SP2V_HIGH), int'(state_we_o));
    compare({name, " key expand clear"}, 1, int'(key_expand_clear_o));
    @(negedge clk_i);
    in_valid_i = SP2V_LOW;
    crypt_i    = SP2V_LOW;
    wait_out_valid();
    // Back-pressure, output must hold
    repeat (3) begin
      @(posedge clk_i);
      compare({name, " held out_valid"}, int'(SP2V_HIGH), int'(out_valid_o));
      compare({name, " held crypt"}, int'(SP2V_HIGH), int'(crypt_o));
    end
    @(negedge clk_i);
    out_ready_i = SP2V_HIGH;
    @(posedge clk_i);
    compare({name, " handshake"}, int'(SP2V_HIGH), int'(out_valid_o));
    @(negedge clk_i);
    out_ready_i = SP2V_LOW;
    @(posedge clk_i);
    compare({name, " ready again"}, int'(SP2V_HIGH), int'(in_ready_o));
    compare({name, " sub bytes acks"}, expv.sb_acks, sb_count);
    compare({name, " key expand acks"}, expv.ke_acks, ke_count);
  endtask

  task automatic clear_request(input logic key_clr, input logic data_clr);
    string name;
    name = $sformatf("clear key=%0d data=%0d", key_clr, data_clr);
    @(negedge clk_i);
    in_valid_i       = SP2V_HIGH;
    key_clear_i      = key_clr;
    data_out_clear_i = data_clr;
    out_ready_i      = SP2V_HIGH;
    @(posedge clk_i);
    compare({name, " accept"}, int'(SP2V_HIGH), int'(in_ready_o));
    @(negedge clk_i);
    in_valid_i       = SP2V_LOW;
    key_clear_i      = 1'b0;
    data_out_clear_i = 1'b0;
    // Data output clear spends one cycle clearing the state first
    if (data_clr) begin
      @(posedge clk_i);
      compare({name, " early out_valid"}, int'(SP2V_LOW), int'(out_valid_o));
      compare({name, " state clear sel"}, int'(STATE_CLEAR), int'(state_sel_o));
      compare({name, " state clear we"}, int'(SP2V_HIGH), int'(state_we_o));
    end
    @(posedge clk_i);
    compare({name, " out_valid"}, int'(SP2V_HIGH), int'(out_valid_o));
    compare({name, " key we"}, int'(key_clr ? SP2V_HIGH : SP2V_LOW), int'(key_full_we_o));
    if (key_clr) compare({name, " key sel"}, int'(KEY_FULL_CLEAR), int'(key_full_sel_o));
    compare({name, " key clear flag"}, int'(key_clr), int'(key_clear_o));
    compare({name, " data clear flag"}, int'(data_clr), int'(data_out_clear_o));
    @(negedge clk_i);
    out_ready_i = SP2V_LOW;
    @(posedge clk_i);
    compare({name, " key we after"}, int'(SP2V_LOW), int'(key_full_we_o));
    compare({name, " ready again"}, int'(SP2V_HIGH), int'(in_ready_o));
    compare({name, " key clear flag after"}, 0, int'(key_clear_o));
    compare({name, " data clear flag after"}, 0, int'(data_out_clear_o));
  endtask

  task automatic invalid_code_trap();
    @(negedge clk_i);
    in_valid_i = sp2v_e'(3'b000);
    @(negedge clk_i);
    in_valid_i = SP2V_LOW;
    // Error state is terminal
    repeat (3) begin
      @(posedge clk_i);
      compare("invalid code alert", 1, int'(alert_o));
      compare("invalid code ready", int'(SP2V_LOW), int'(in_ready_o));
    end
  endtask

  initial begin : stimulus
    key_len_e lens [3];
    lens                 = '{AES_128, AES_192, AES_256};
    rst_ni               = 1'b0;
    in_valid_i           = SP2V_LOW;
    out_ready_i          = SP2V_LOW;
    crypt_i              = SP2V_LOW;
    sub_bytes_out_req_i  = SP2V_LOW;
    key_expand_out_req_i = SP2V_LOW;
    op_i                 = CIPH_FWD;
    key_len_i            = AES_128;
    key_clear_i          = 1'b0;
    data_out_clear_i     = 1'b0;
    sb_count             = 0;
    ke_count             = 0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    compare("reset in_ready", int'(SP2V_HIGH), int'(in_ready_o));
    compare("reset out_valid", int'(SP2V_LOW), int'(out_valid_o));
    compare("reset alert", 0, int'(alert_o));
    compare("reset round", 0, int'(key_expand_round_o));
    for (int i = 0; i < 3; i++) begin
      crypt_round_trip(lens[i], CIPH_FWD);
      crypt_round_trip(lens[i], CIPH_INV);
    end
    clear_request(1'b1, 1'b0);
    clear_request(1'b0, 1'b1);
    invalid_code_trap();
    $display("Testbench passed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+common
common/aes_ctrl_pkg.sv
common/aes_ctrl_if.sv
src/aes_sp2v_check.sv
src/aes_round_ctr.sv
cipher_ctrl/aes_cipher_fsm.sv
cipher_ctrl/aes_cipher_ctrl.sv
test/tb_aes_cipher_ctrl.sv
